// File: verilog/ucodeCore_params.svh
`ifndef UCODECORE_PARAMS_SVH
`define UCODECORE_PARAMS_SVH

// Register and immediate width
`define DATA_W 8

// Flow index width, the ROM holds up to 1 << FLOW_W words
`define FLOW_W 6
`define ROM_DEPTH (1 << `FLOW_W)

// Micro-op word: sequence bit, 4-bit operation, source bit
`define UOP_W 6

// Decoded flows waiting between decoder and engine
`define QUEUE_DEPTH 4

`endif

// File: verilog/isaPkg.sv
`include "ucodeCore_params.svh"

package isaPkg;

	// Raw opcode byte as fetched
	typedef logic [7:0] opcode_t;

	// Register contents and immediates
	typedef logic [`DATA_W-1:0] data_t;

	// Entry address into the micro-op ROM
	typedef logic [`FLOW_W-1:0] flowIdx_t;

	// Z, N, C packed high to low
	typedef logic [2:0] flags_t;

	// Register field of the opcode, 3'b110 selects (HL) and is not kept
	typedef enum logic [2:0] {
		idxB = 3'd0,
		idxC = 3'd1,
		idxD = 3'd2,
		idxE = 3'd3,
		idxH = 3'd4,
		idxL = 3'd5,
		idxA = 3'd7
	} regIdx_t;

	// Bit positions inside flags_t
	localparam int flagZ = 2;
	localparam int flagN = 1;
	localparam int flagC = 0;

endpackage

// File: verilog/uopPkg.sv
`include "ucodeCore_params.svh"

package uopPkg;

	typedef enum logic {seqNext, seqEnd} uopSeq_t;

	typedef enum logic [3:0] {
		opNop, opLoadX, opLoadImm, opAddX, opAdcX, opSubX,
		opSbcX, opStoreX, opIncR, opDecR, opCmpX
	} uopOp_t;

	// Register operand of the flow, or the accumulator
	typedef enum logic {srcOpnd, srcAcc} uopSrc_t;

	typedef logic [`UOP_W-1:0] uopWord_t;

	// Field positions in uopWord_t
	localparam int seqBit = 5;
	localparam int opMsb = 4;
	localparam int opLsb = 1;
	localparam int srcBit = 0;

	// Flow entry points in the ROM
	localparam isaPkg::flowIdx_t flowNop = `FLOW_W'(0);
	localparam isaPkg::flowIdx_t flowLd = `FLOW_W'(1);
	localparam isaPkg::flowIdx_t flowInc = `FLOW_W'(3);
	localparam isaPkg::flowIdx_t flowDec = `FLOW_W'(5);
	localparam isaPkg::flowIdx_t flowAdd = `FLOW_W'(7);
	localparam isaPkg::flowIdx_t flowAdc = `FLOW_W'(10);
	localparam isaPkg::flowIdx_t flowSub = `FLOW_W'(13);
	localparam isaPkg::flowIdx_t flowSbc = `FLOW_W'(16);
	localparam isaPkg::flowIdx_t flowCp = `FLOW_W'(19);

endpackage

// File: verilog/flowIf.sv
`timescale 1ns/1ps

// Decoded flow handshake, payload held while valid waits for ready
interface flowIf import isaPkg::*; ();

	logic valid;
	logic ready;
	flowIdx_t flowIdx;
	regIdx_t regSel;
	data_t imm;
	opcode_t opcode;

	modport source (
		output valid, flowIdx, regSel, imm, opcode,
		input ready
	);

	modport sink (
		input valid, flowIdx, regSel, imm, opcode,
		output ready
	);

endinterface

// File: verilog/opcodeDecoder.sv
`timescale 1ns/1ps

module opcodeDecoder
	import isaPkg::*;
	import uopPkg::*;
(
	input  logic    clk,
	input  logic    rst,
	input  logic    opValid,
	input  opcode_t opCode,
	input  data_t   opImm,
	output logic    opReady,
	flowIf.source   decFlow
);

	flowIdx_t flowSel;
	regIdx_t regSel;
	regIdx_t dstField;
	regIdx_t srcField;
	logic dstIsMem;
	logic srcIsMem;
	logic accept;
	logic holdNext;

	assign dstField = regIdx_t'(opCode[5:3]);
	assign srcField = regIdx_t'(opCode[2:0]);
	assign dstIsMem = (opCode[5:3] == 3'b110);
	assign srcIsMem = (opCode[2:0] == 3'b110);
	assign accept = opValid && opReady;

	// Entry stays until the queue takes it
	assign holdNext = accept || (decFlow.valid && !decFlow.ready);

	//////////////////////////////////////////////////////////////////////
	// Opcode to flow lookup, anything not kept runs the NOP flow
	//////////////////////////////////////////////////////////////////////
	always_comb
	begin
		flowSel = flowNop;
		regSel = idxA;
		casez (opCode)
			8'b00???110:
			begin
				if (!dstIsMem)
				begin
					flowSel = flowLd;
					regSel = dstField;
				end
			end
			8'b00???100:
			begin
				if (!dstIsMem)
				begin
					flowSel = flowInc;
					regSel = dstField;
				end
			end
			8'b00???101:
			begin
				if (!dstIsMem)
				begin
					flowSel = flowDec;
					regSel = dstField;
				end
			end
			8'b10000???:
			begin
				if (!srcIsMem)
				begin
					flowSel = flowAdd;
					regSel = srcField;
				end
			end
			8'b10001???:
			begin
				if (!srcIsMem)
				begin
					flowSel = flowAdc;
					regSel = srcField;
				end
			end
			8'b10010???:
			begin
				if (!srcIsMem)
				begin
					flowSel = flowSub;
					regSel = srcField;
				end
			end
			8'b10011???:
			begin
				if (!srcIsMem)
				begin
					flowSel = flowSbc;
					regSel = srcField;
				end
			end
			8'b10111???:
			begin
				if (!srcIsMem)
				begin
					flowSel = flowCp;
					regSel = srcField;
				end
			end
			default:
			begin
				flowSel = flowNop;
			end
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			decFlow.valid <= 1'b0;
			opReady <= 1'b0;
		end
		else
		begin
			decFlow.valid <= holdNext;
			opReady <= !holdNext;
		end
	end

	// Output entry, loaded only when empty
	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			decFlow.flowIdx <= flowSel;
			decFlow.regSel <= regSel;
			decFlow.imm <= opImm;
			decFlow.opcode <= opCode;
		end
	end

endmodule

// File: verilog/flowQueue.sv
`timescale 1ns/1ps
`include "ucodeCore_params.svh"

module flowQueue
	import isaPkg::*;
(
	input  logic clk,
	input  logic rst,
	flowIf.sink  decFlow,
	flowIf.source execFlow
);

	localparam int ptrW = (`QUEUE_DEPTH > 1) ? $clog2(`QUEUE_DEPTH) : 1;
	localparam int cntW = $clog2(`QUEUE_DEPTH + 1);
	localparam logic [cntW-1:0] fullCount = cntW'(`QUEUE_DEPTH);
	localparam logic [ptrW-1:0] lastSlot = ptrW'(`QUEUE_DEPTH - 1);

	flowIdx_t flowMem [`QUEUE_DEPTH];
	regIdx_t regMem [`QUEUE_DEPTH];
	data_t immMem [`QUEUE_DEPTH];
	opcode_t opMem [`QUEUE_DEPTH];

	logic [ptrW-1:0] wrPtr;
	logic [ptrW-1:0] rdPtr;
	logic [cntW-1:0] count;
	logic push;
	logic pop;

	assign decFlow.ready = (count != fullCount);
	assign execFlow.valid = (count != '0);
	assign push = decFlow.valid && decFlow.ready;
	assign pop = execFlow.valid && execFlow.ready;

	// Head entry
	assign execFlow.flowIdx = flowMem[rdPtr];
	assign execFlow.regSel = regMem[rdPtr];
	assign execFlow.imm = immMem[rdPtr];
	assign execFlow.opcode = opMem[rdPtr];

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end
		else
		begin
			if (push)
				wrPtr <= (wrPtr == lastSlot) ? '0 : wrPtr + 1'b1;
			if (pop)
				rdPtr <= (rdPtr == lastSlot) ? '0 : rdPtr + 1'b1;
			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (push)
		begin
			flowMem[wrPtr] <= decFlow.flowIdx;
			regMem[wrPtr] <= decFlow.regSel;
			immMem[wrPtr] <= decFlow.imm;
			opMem[wrPtr] <= decFlow.opcode;
		end
	end

endmodule

// File: verilog/uopRom.sv
`timescale 1ns/1ps

module uopRom
	import isaPkg::*;
	import uopPkg::*;
(
	input  flowIdx_t addr,
	output uopWord_t word
);

	//////////////////////////////////////////////////////////////////////
	// Micro-op flows, one word per cycle
	// Word layout is {sequence, operation, source}
	//////////////////////////////////////////////////////////////////////
	always_comb
	begin
		case (addr)
			// NOP and every opcode not kept
			flowNop:        word = {seqEnd,  opNop,     srcOpnd};

			// LD r,n
			flowLd:         word = {seqNext, opLoadImm, srcOpnd};
			flowLd + 1'b1:  word = {seqEnd,  opStoreX,  srcOpnd};

			// INC r, result written back on the last word
			flowInc:        word = {seqNext, opIncR,    srcOpnd};
			flowInc + 1'b1: word = {seqEnd,  opStoreX,  srcOpnd};

			// DEC r
			flowDec:        word = {seqNext, opDecR,    srcOpnd};
			flowDec + 1'b1: word = {seqEnd,  opStoreX,  srcOpnd};

			// ADD A,r
			flowAdd:        word = {seqNext, opLoadX,   srcAcc};
			flowAdd + 1'b1: word = {seqNext, opAddX,    srcOpnd};
			flowAdd + 2'd2: word = {seqEnd,  opStoreX,  srcAcc};

			// ADC A,r
			flowAdc:        word = {seqNext, opLoadX,   srcAcc};
			flowAdc + 1'b1: word = {seqNext, opAdcX,    srcOpnd};
			flowAdc + 2'd2: word = {seqEnd,  opStoreX,  srcAcc};

			// SUB A,r
			flowSub:        word = {seqNext, opLoadX,   srcAcc};
			flowSub + 1'b1: word = {seqNext, opSubX,    srcOpnd};
			flowSub + 2'd2: word = {seqEnd,  opStoreX,  srcAcc};

			// SBC A,r
			flowSbc:        word = {seqNext, opLoadX,   srcAcc};
			flowSbc + 1'b1: word = {seqNext, opSbcX,    srcOpnd};
			flowSbc + 2'd2: word = {seqEnd,  opStoreX,  srcAcc};

			// CP r, flags only
			flowCp:         word = {seqNext, opLoadX,   srcAcc};
			flowCp + 1'b1:  word = {seqNext, opCmpX,    srcOpnd};
			flowCp + 2'd2:  word = {seqEnd,  opNop,     srcOpnd};

			// Unused words end the flow
			default:        word = {seqEnd,  opNop,     srcOpnd};
		endcase
	end

endmodule

// File: verilog/uopEngine.sv
`timescale 1ns/1ps
`include "ucodeCore_params.svh"

module uopEngine
	import isaPkg::*;
	import uopPkg::*;
(
	input  logic    clk,
	input  logic    rst,
	flowIf.sink     execFlow,
	output logic    retireValid,
	output opcode_t retireOpcode,
	output data_t   regA,
	output flags_t  flags
);

	typedef enum logic {stIdle, stRun} engState_t;

	localparam logic [`DATA_W:0] wideOne = (`DATA_W + 1)'(1);

	engState_t state;
	flowIdx_t upc;
	regIdx_t curReg;
	data_t curImm;
	opcode_t curOpcode;
	data_t xReg;
	data_t regFile [8];
	flags_t pendFlags;

	uopWord_t word;
	uopSeq_t seq;
	uopOp_t op;
	uopSrc_t src;
	regIdx_t srcIdx;
	data_t operand;
	logic carryIn;
	logic running;
	logic [`DATA_W:0] aluWide;
	data_t aluRes;
	flags_t flagsNext;

	uopRom rom (
		.addr(upc),
		.word(word)
	);

	// Word fields
	assign seq = uopSeq_t'(word[seqBit]);
	assign op = uopOp_t'(word[opMsb:opLsb]);
	assign src = uopSrc_t'(word[srcBit]);

	assign srcIdx = (src == srcAcc) ? idxA : curReg;
	assign operand = regFile[srcIdx];
	assign carryIn = pendFlags[flagC];
	assign running = (state == stRun);
	assign execFlow.ready = (state == stIdle);
	assign regA = regFile[idxA];

	//////////////////////////////////////////////////////////////////////
	// ALU, bit DATA_W is carry out or borrow
	//////////////////////////////////////////////////////////////////////
	always_comb
	begin
		case (op)
			opAddX: aluWide = {1'b0, xReg} + {1'b0, operand};
			opAdcX: aluWide = {1'b0, xReg} + {1'b0, operand} + {{`DATA_W{1'b0}}, carryIn};
			opSubX, opCmpX: aluWide = {1'b0, xReg} - {1'b0, operand};
			opSbcX: aluWide = {1'b0, xReg} - {1'b0, operand} - {{`DATA_W{1'b0}}, carryIn};
			opIncR: aluWide = {1'b0, operand} + wideOne;
			opDecR: aluWide = {1'b0, operand} - wideOne;
			default: aluWide = {1'b0, operand};
		endcase
	end

	assign aluRes = aluWide[`DATA_W-1:0];

	// INC and DEC keep C
	always_comb
	begin
		flagsNext = pendFlags;
		case (op)
			opAddX, opAdcX, opSubX, opSbcX, opCmpX:
			begin
				flagsNext[flagZ] = (aluRes == '0);
				flagsNext[flagN] = (op != opAddX) && (op != opAdcX);
				flagsNext[flagC] = aluWide[`DATA_W];
			end
			opIncR, opDecR:
			begin
				flagsNext[flagZ] = (aluRes == '0);
				flagsNext[flagN] = (op == opDecR);
			end
			default:
			begin
				flagsNext = pendFlags;
			end
		endcase
	end

	//////////////////////////////////////////////////////////////////////
	// Sequencer and architectural state
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state <= stIdle;
			upc <= '0;
			pendFlags <= '0;
			flags <= '0;
			retireValid <= 1'b0;
			for (int i = 0; i < 8; i++)
				regFile[i] <= '0;
		end
		else
		begin
			retireValid <= running && (seq == seqEnd);
			if (!running)
			begin
				if (execFlow.valid)
				begin
					state <= stRun;
					upc <= execFlow.flowIdx;
					pendFlags <= flags;
				end
			end
			else
			begin
				upc <= upc + 1'b1;
				pendFlags <= flagsNext;
				if (op == opStoreX)
					regFile[srcIdx] <= xReg;
				// Flags become visible with the end of the flow
				if (seq == seqEnd)
				begin
					state <= stIdle;
					flags <= flagsNext;
				end
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (execFlow.valid && execFlow.ready)
		begin
			curReg <= execFlow.regSel;
			curImm <= execFlow.imm;
			curOpcode <= execFlow.opcode;
		end
		if (running)
		begin
			case (op)
				opLoadX: xReg <= operand;
				opLoadImm: xReg <= curImm;
				opAddX, opAdcX, opSubX, opSbcX, opIncR, opDecR: xReg <= aluRes;
				default: xReg <= xReg;
			endcase
			if (seq == seqEnd)
				retireOpcode <= curOpcode;
		end
	end

endmodule

// File: verilog/ucodeCore.sv
`timescale 1ns/1ps

module ucodeCore
	import isaPkg::*;
(
	input  logic    clk,
	input  logic    rst,
	input  logic    opValid,
	input  opcode_t opCode,
	input  data_t   opImm,
	output logic    opReady,
	output logic    retireValid,
	output opcode_t retireOpcode,
	output data_t   regA,
	output flags_t  flags
);

	// Decoder to queue, queue to engine
	flowIf decFlow ();
	flowIf execFlow ();

	opcodeDecoder decoder (
		.clk(clk),
		.rst(rst),
		.opValid(opValid),
		.opCode(opCode),
		.opImm(opImm),
		.opReady(opReady),
		.decFlow(decFlow)
	);

	flowQueue queue (
		.clk(clk),
		.rst(rst),
		.decFlow(decFlow),
		.execFlow(execFlow)
	);

	uopEngine engine (
		.clk(clk),
		.rst(rst),
		.execFlow(execFlow),
		.retireValid(retireValid),
		.retireOpcode(retireOpcode),
		.regA(regA),
		.flags(flags)
	);

endmodule

// File: verif/ucodeCore_sva.sv
`timescale 1ns/1ps

module ucodeCore_sva
	import isaPkg::*;
(
	input logic     clk,
	input logic     rst,
	input logic     opReady,
	input logic     decValid,
	input logic     decReady,
	input flowIdx_t decFlowIdx,
	input regIdx_t  decRegSel,
	input data_t    decImm,
	input opcode_t  decOpcode,
	input logic     execValid,
	input logic     execReady,
	input flowIdx_t execFlowIdx,
	input regIdx_t  execRegSel,
	input data_t    execImm,
	input opcode_t  execOpcode,
	input logic     retireValid,
	input data_t    regA,
	input flags_t   flags
);

	// Decoder entry waits while the queue is full
	decHold: assert property (@(posedge clk) disable iff (rst)
		decValid && !decReady |=>
			decValid && $stable({decFlowIdx, decRegSel, decImm, decOpcode}))
		else $error("decoder entry changed or dropped while the queue was full");

	// Queue head waits while the engine runs a flow
	execHold: assert property (@(posedge clk) disable iff (rst)
		execValid && !execReady |=>
			execValid && $stable({execFlowIdx, execRegSel, execImm, execOpcode}))
		else $error("queue head changed or dropped while the engine was busy");

	retirePulse: assert property (@(posedge clk) disable iff (rst)
		retireValid |=> !retireValid)
		else $error("retireValid held for more than one cycle");

	resetState: assert property (@(posedge clk)
		rst |=> !retireValid && !opReady && !decValid && !execValid
			&& regA == '0 && flags == '0)
		else $error("state not cleared by reset");

endmodule

bind ucodeCore ucodeCore_sva sva (
	.clk(clk),
	.rst(rst),
	.opReady(opReady),
	.decValid(decFlow.valid),
	.decReady(decFlow.ready),
	.decFlowIdx(decFlow.flowIdx),
	.decRegSel(decFlow.regSel),
	.decImm(decFlow.imm),
	.decOpcode(decFlow.opcode),
	.execValid(execFlow.valid),
	.execReady(execFlow.ready),
	.execFlowIdx(execFlow.flowIdx),
	.execRegSel(execFlow.regSel),
	.execImm(execFlow.imm),
	.execOpcode(execFlow.opcode),
	.retireValid(retireValid),
	.regA(regA),
	.flags(flags)
);

// File: verif/ucodeCoreChecker.sv
`timescale 1ns/1ps

module ucodeCoreChecker (
	input logic       clk,
	input logic       rst,
	input logic       opValid,
	input logic       opReady,
	input logic [7:0] opCode,
	input logic [7:0] opImm,
	input logic       expChk,
	input logic [7:0] expA,
	input logic [2:0] expF,
	input logic       retireValid,
	input logic [7:0] retireOpcode,
	input logic [7:0] regA,
	input logic [2:0] flags
);

	int errCount = 0;
	int retireCount = 0;

	// Reference model, A is index 7, flags are {Z, N, C}
	logic [7:0] mReg [8];
	logic [2:0] mFlags;
	logic [7:0] lastA;
	logic [2:0] lastF;

	// Outstanding instructions in order
	logic [7:0] qOp[$];
	logic [7:0] qA[$];
	logic [2:0] qF[$];
	logic qChk[$];
	logic [7:0] qTabA[$];
	logic [2:0] qTabF[$];

	task automatic modelStep(input logic [7:0] op, input logic [7:0] imm);
		logic [2:0] dst;
		logic [2:0] src;
		logic [8:0] wide;
		logic cIn;
		dst = op[5:3];
		src = op[2:0];
		cIn = mFlags[0];
		if (op[7:6] == 2'b00 && dst != 3'd6)
		begin
			if (src == 3'b110)
				mReg[dst] = imm;
			else if (src == 3'b100)
			begin
				wide = {1'b0, mReg[dst]} + 9'd1;
				mReg[dst] = wide[7:0];
				mFlags = {wide[7:0] == 8'h00, 1'b0, cIn};
			end
			else if (src == 3'b101)
			begin
				wide = {1'b0, mReg[dst]} - 9'd1;
				mReg[dst] = wide[7:0];
				mFlags = {wide[7:0] == 8'h00, 1'b1, cIn};
			end
		end
		else if (op[7:6] == 2'b10 && src != 3'd6 && dst inside {0, 1, 2, 3, 7})
		begin
			case (dst)
				3'd0: wide = {1'b0, mReg[7]} + {1'b0, mReg[src]};
				3'd1: wide = {1'b0, mReg[7]} + {1'b0, mReg[src]} + {8'h00, cIn};
				3'd3: wide = {1'b0, mReg[7]} - {1'b0, mReg[src]} - {8'h00, cIn};
				default: wide = {1'b0, mReg[7]} - {1'b0, mReg[src]};
			endcase
			// Bit 8 is carry for additions and borrow for subtractions
			mFlags = {wide[7:0] == 8'h00, dst > 3'd1, wide[8]};
			if (dst != 3'd7)
				mReg[7] = wide[7:0];
		end
	endtask

	always @(posedge clk)
	begin
		if (rst)
		begin
			for (int i = 0; i < 8; i++)
				mReg[i] = 8'h00;
			mFlags = 3'b000;
			lastA = 8'h00;
			lastF = 3'b000;
			qOp.delete();
			qA.delete();
			qF.delete();
			qChk.delete();
			qTabA.delete();
			qTabF.delete();
		end
		else
		begin
			if (retireValid)
			begin
				if (qOp.size() == 0)
				begin
					$display("Error at %0t: retire with no instruction outstanding", $time);
					errCount++;
				end
				else
				begin
					retireCount++;
					if (retireOpcode !== qOp[0])
					begin
						$display("MISMATCH at %0t: opcode %h, expected %h",
							$time, retireOpcode, qOp[0]);
						errCount++;
					end
					if (regA !== qA[0] || flags !== qF[0])
					begin
						$display("MISMATCH at %0t: op %h A=%h F=%b, model A=%h F=%b",
							$time, qOp[0], regA, flags, qA[0], qF[0]);
						errCount++;
					end
					if (qChk[0] && (regA !== qTabA[0] || flags !== qTabF[0]))
					begin
						$display("MISMATCH at %0t: op %h A=%h F=%b, table A=%h F=%b",
							$time, qOp[0], regA, flags, qTabA[0], qTabF[0]);
						errCount++;
					end
					lastA = qA.pop_front();
					lastF = qF.pop_front();
					void'(qOp.pop_front());
					void'(qChk.pop_front());
					void'(qTabA.pop_front());
					void'(qTabF.pop_front());
				end
			end
			else if (regA !== lastA || flags !== lastF)
			begin
				// A and flags only move together with a retire
				$display("MISMATCH at %0t: A=%h F=%b changed outside a retire, expected A=%h F=%b",
					$time, regA, flags, lastA, lastF);
				errCount++;
			end
			if (opValid && opReady)
			begin
				modelStep(opCode, opImm);
				qOp.push_back(opCode);
				qA.push_back(mReg[7]);
				qF.push_back(mFlags);
				qChk.push_back(expChk);
				qTabA.push_back(expA);
				qTabF.push_back(expF);
			end
		end
	end

endmodule

// File: verif/ucodeCoreTb.sv
`timescale 1ns/1ps

module tbClockGen #(
	parameter int periodNs = 20
) (
	output logic clk
);

	initial
	begin
		clk = 1'b0;
		forever #(periodNs / 2) clk = ~clk;
	end

endmodule

module ucodeCoreTb;

	localparam int periodNs = 20;
	localparam int resetCycles = 5;
	localparam int randomRows = 40;
	localparam int lastTest = 6;

	logic clk;
	logic rst;
	logic opValid;
	logic [7:0] opCode;
	logic [7:0] opImm;
	logic opReady;
	logic retireValid;
	logic [7:0] retireOpcode;
	logic [7:0] regA;
	logic [2:0] flags;

	// Expected values that travel with each instruction
	logic expChk;
	logic [7:0] expA;
	logic [2:0] expF;

	// Stimulus table columns are test, opcode, immediate, check, A, flags and gap
	int rowTest[$];
	logic [7:0] rowOp[$];
	logic [7:0] rowImm[$];
	logic rowChk[$];
	logic [7:0] rowA[$];
	logic [2:0] rowF[$];
	int rowGap[$];

	int seed;
	int sentCount;
	int tbErrors;
	int stallRun;
	logic tableReady;
	logic burstPhase;
	logic sawStall;

	tbClockGen #(.periodNs(periodNs)) clkGen (.clk(clk));

	ucodeCore UUT (
		.clk(clk),
		.rst(rst),
		.opValid(opValid),
		.opCode(opCode),
		.opImm(opImm),
		.opReady(opReady),
		.retireValid(retireValid),
		.retireOpcode(retireOpcode),
		.regA(regA),
		.flags(flags)
	);

	ucodeCoreChecker chk (
		.clk(clk),
		.rst(rst),
		.opValid(opValid),
		.opReady(opReady),
		.opCode(opCode),
		.opImm(opImm),
		.expChk(expChk),
		.expA(expA),
		.expF(expF),
		.retireValid(retireValid),
		.retireOpcode(retireOpcode),
		.regA(regA),
		.flags(flags)
	);

	task automatic addRow(input int test, input logic [7:0] op, input logic [7:0] imm,
		input logic chkRow, input logic [7:0] a, input logic [2:0] f, input int gap);
		rowTest.push_back(test);
		rowOp.push_back(op);
		rowImm.push_back(imm);
		rowChk.push_back(chkRow);
		rowA.push_back(a);
		rowF.push_back(f);
		rowGap.push_back(gap);
	endtask

	function automatic string testName(input int id);
		case (id)
			1: return "reset state and NOP";
			2: return "LD, ADD and SUB";
			3: return "ADC, SBC, INC and DEC";
			4: return "CP and unsupported opcodes";
			5: return "back-to-back burst";
			default: return "random instructions";
		endcase
	endfunction

	task automatic fillTable();
		logic [2:0] regPick [7];
		logic [2:0] r;
		int kind;
		regPick = '{3'd0, 3'd1, 3'd2, 3'd3, 3'd4, 3'd5, 3'd7};
		// Flags column is {Z, N, C}
		addRow(1, 8'h00, 8'h00, 1, 8'h00, 3'b000, 1);
		addRow(2, 8'h3E, 8'hFF, 1, 8'hFF, 3'b000, 1);
		addRow(2, 8'h06, 8'h01, 1, 8'hFF, 3'b000, 0);
		addRow(2, 8'h80, 8'h00, 1, 8'h00, 3'b101, 1);
		addRow(2, 8'h3E, 8'h10, 1, 8'h10, 3'b101, 0);
		addRow(2, 8'h0E, 8'h20, 1, 8'h10, 3'b101, 2);
		addRow(2, 8'h91, 8'h00, 1, 8'hF0, 3'b011, 0);
		addRow(2, 8'h81, 8'h00, 1, 8'h10, 3'b001, 1);
		addRow(2, 8'h90, 8'h00, 1, 8'h0F, 3'b010, 0);
		addRow(3, 8'h3E, 8'hF0, 1, 8'hF0, 3'b010, 0);
		addRow(3, 8'h16, 8'h20, 1, 8'hF0, 3'b010, 1);
		addRow(3, 8'h82, 8'h00, 1, 8'h10, 3'b001, 0);
		addRow(3, 8'h8A, 8'h00, 1, 8'h31, 3'b000, 0);
		addRow(3, 8'h8A, 8'h00, 1, 8'h51, 3'b000, 2);
		addRow(3, 8'h1E, 8'h60, 1, 8'h51, 3'b000, 0);
		addRow(3, 8'h93, 8'h00, 1, 8'hF1, 3'b011, 0);
		addRow(3, 8'h9B, 8'h00, 1, 8'h90, 3'b010, 1);
		addRow(3, 8'h9B, 8'h00, 1, 8'h30, 3'b010, 0);
		addRow(3, 8'h3C, 8'h00, 1, 8'h31, 3'b000, 0);
		addRow(3, 8'h3E, 8'hFF, 1, 8'hFF, 3'b000, 1);
		addRow(3, 8'h80, 8'h00, 1, 8'h00, 3'b101, 0);
		addRow(3, 8'h3C, 8'h00, 1, 8'h01, 3'b001, 0);
		addRow(3, 8'h3D, 8'h00, 1, 8'h00, 3'b111, 1);
		addRow(3, 8'h05, 8'h00, 1, 8'h00, 3'b111, 0);
		addRow(3, 8'h04, 8'h00, 1, 8'h00, 3'b001, 0);
		addRow(4, 8'h3E, 8'h40, 1, 8'h40, 3'b001, 0);
		addRow(4, 8'h26, 8'h50, 1, 8'h40, 3'b001, 0);
		addRow(4, 8'hBC, 8'h00, 1, 8'h40, 3'b011, 1);
		addRow(4, 8'h2E, 8'h40, 1, 8'h40, 3'b011, 0);
		addRow(4, 8'hBD, 8'h00, 1, 8'h40, 3'b110, 0);
		addRow(4, 8'h76, 8'h00, 1, 8'h40, 3'b110, 1);
		addRow(4, 8'hA0, 8'h00, 1, 8'h40, 3'b110, 0);
		addRow(4, 8'h36, 8'h12, 1, 8'h40, 3'b110, 0);
		// Burst with no gaps fills the queue
		addRow(5, 8'h3E, 8'h01, 1, 8'h01, 3'b110, 0);
		for (int i = 0; i < 12; i++)
			addRow(5, 8'h80, 8'h00, 1, 8'(i + 2), 3'b000, 0);
		// Random rows are checked against the model only
		for (int i = 0; i < randomRows; i++)
		begin
			kind = $unsigned($random(seed)) % 8;
			r = regPick[$unsigned($random(seed)) % 7];
			case (kind)
				0: addRow(6, {2'b00, r, 3'b110}, 8'($random(seed)), 0, 0, 0, 0);
				1: addRow(6, {2'b00, r, 3'b100}, 8'h00, 0, 0, 0, 0);
				2: addRow(6, {2'b00, r, 3'b101}, 8'h00, 0, 0, 0, 0);
				3: addRow(6, {5'b10000, r}, 8'h00, 0, 0, 0, 0);
				4: addRow(6, {5'b10001, r}, 8'h00, 0, 0, 0, 0);
				5: addRow(6, {5'b10010, r}, 8'h00, 0, 0, 0, 0);
				6: addRow(6, {5'b10011, r}, 8'h00, 0, 0, 0, 0);
				default: addRow(6, {5'b10111, r}, 8'h00, 0, 0, 0, 0);
			endcase
			rowGap[rowGap.size() - 1] = $unsigned($random(seed)) % 3;
		end
	endtask

	// Offers the instruction and holds it until an edge with opReady high
	task automatic sendRow(input int idx);
		opValid = 1'b1;
		opCode = rowOp[idx];
		opImm = rowImm[idx];
		expChk = rowChk[idx];
		expA = rowA[idx];
		expF = rowF[idx];
		while (!opReady)
		begin
			@(posedge clk);
			#1;
		end
		@(posedge clk);
		sentCount++;
		#1;
		opValid = 1'b0;
		expChk = 1'b0;
		if (rowGap[idx] > 0)
		begin
			repeat (rowGap[idx]) @(posedge clk);
			#1;
		end
	endtask

	// A full queue keeps opReady low longer than the one cycle after an accept
	always @(posedge clk)
	begin
		if (rst || !burstPhase || !opValid || opReady)
			stallRun <= 0;
		else
			stallRun <= stallRun + 1;
		if (!rst && burstPhase && opValid && !opReady && stallRun >= 1)
			sawStall <= 1'b1;
	end

	//////////////////////////////////////////////////////////////////////
	// Watchdog allows 10 cycles per row plus reset
	//////////////////////////////////////////////////////////////////////
	initial
	begin
		wait (tableReady);
		#((rowTest.size() * 10 + resetCycles + 10) * periodNs);
		$display("Test FAILED");
		$display("Timeout: the DUT did not retire all instructions in time");
		$finish;
	end

	initial
	begin
		int errBefore;
		int errNow;
		seed = 32'haa9d_21d8;
		tableReady = 1'b0;
		burstPhase = 1'b0;
		sawStall = 1'b0;
		sentCount = 0;
		tbErrors = 0;
		rst = 1'b1;
		opValid = 1'b0;
		opCode = 8'h00;
		opImm = 8'h00;
		expChk = 1'b0;
		expA = 8'h00;
		expF = 3'b000;
		fillTable();
		tableReady = 1'b1;
		repeat (resetCycles) @(posedge clk);
		#1;
		rst = 1'b0;
		// Idle stretch, nothing may retire here
		repeat (4) @(posedge clk);
		#1;

		for (int t = 1; t <= lastTest; t++)
		begin
			errBefore = chk.errCount + tbErrors;
			burstPhase = (t == 5);
			for (int i = 0; i < rowTest.size(); i++)
			begin
				if (rowTest[i] == t)
					sendRow(i);
			end
			while (chk.retireCount < sentCount)
			begin
				@(posedge clk);
				#1;
			end
			if (t == 5)
			begin
				burstPhase = 1'b0;
				if (!sawStall)
				begin
					$display("Error: the queue never filled, opReady never held back the burst");
					tbErrors++;
				end
			end
			errNow = chk.errCount + tbErrors - errBefore;
			$display("Test %0d (%s): %0d errors", t, testName(t), errNow);
		end

		repeat (3) @(posedge clk);
		$display("Tests: %0d, instructions retired: %0d, errors: %0d",
			lastTest, chk.retireCount, chk.errCount + tbErrors);
		if (chk.errCount + tbErrors == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

endmodule

// File: filelist.f
+incdir+verilog
verilog/isaPkg.sv
verilog/uopPkg.sv
verilog/flowIf.sv
verilog/opcodeDecoder.sv
verilog/flowQueue.sv
verilog/uopRom.sv
verilog/uopEngine.sv
verilog/ucodeCore.sv
verif/ucodeCore_sva.sv
verif/ucodeCoreChecker.sv
verif/ucodeCoreTb.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the ucodeCore testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -j 0 \
	-f filelist.f --top-module ucodeCoreTb -o ucodeCoreSim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/ucodeCoreSim > "$LOG" 2>&1
simStatus=$?
cat "$LOG"
if [ $simStatus -ne 0 ]; then
	echo "Simulation exited with status $simStatus"
	exit 1
fi

if grep -qx "Test OK" "$LOG"; then
	exit 0
fi
echo "Pass message not found in $LOG"
exit 1
